/* tb.f */
verilog/opnd_pkg.sv
verilog/request_ctrl.sv
verilog/instr_field_decode.sv
verilog/reg_operand_select.sv
verilog/mem_address_gen.sv
verilog/operand_combine.sv
verilog/decode_opnds.sv
tb/opnd_checker.sv
tb/tb_decode_opnds.sv

/* Bender.yml */
package:
  name: decode_opnds

sources:
  - verilog/opnd_pkg.sv
  - verilog/request_ctrl.sv
  - verilog/instr_field_decode.sv
  - verilog/reg_operand_select.sv
  - verilog/mem_address_gen.sv
  - verilog/operand_combine.sv
  - verilog/decode_opnds.sv
  - target: test
    files:
      - tb/opnd_checker.sv
      - tb/tb_decode_opnds.sv

/* tb/tb_decode_opnds.sv */
`timescale 1ns/1ps

module tb_decode_opnds;

  localparam int num_requests = 400;
  // A handshake takes five cycles plus a hold of up to three, and reset adds a few
  localparam int cycle_limit  = num_requests * 8 + 100;

  logic                     clk;
  logic                     arst_n;
  logic                     req;
  opnd_pkg::decode_req_t    request;
  logic                     ack;
  opnd_pkg::decode_result_t result;
  int                       value_errors;
  int                       protocol_errors;
  int                       cycles = 0;
  logic [31:0]              lfsr;

  decode_opnds DUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (req),
    .request (request),
    .ack     (ack),
    .result  (result)
  );

  // Watches the handshake and compares every acknowledged result
  opnd_checker u_opnd_checker (
    .clk             (clk),
    .arst_n          (arst_n),
    .req             (req),
    .request         (request),
    .ack             (ack),
    .result          (result),
    .value_errors    (value_errors),
    .protocol_errors (protocol_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois LFSR, one shift for every bit handed out, newest bit at the bottom
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    logic        out;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
        lfsr = lfsr ^ 32'hD000_0001;
      end
      bits = {bits[30:0], out};
    end
    return bits;
  endfunction

  // Effective address of the rm encoding, so a hint can be aimed at it
  function automatic logic [31:0] target_address(input opnd_pkg::decode_req_t r);
    logic [7:0]  modrm;
    logic [7:0]  sib;
    logic        use_sib;
    logic [2:0]  base_reg;
    logic [31:0] base;
    logic [31:0] index;
    logic [31:0] disp;
    int          pos;
    modrm    = r.instr[1];
    sib      = r.instr[2];
    use_sib  = modrm[7:6] != 2'b11 && modrm[2:0] == 3'd4;
    pos      = use_sib ? 3 : 2;
    base_reg = use_sib ? sib[2:0] : modrm[2:0];
    base     = (modrm[7:6] == 2'b00 && base_reg == 3'd5) ? 32'd0 : r.gprs.val[base_reg];
    index    = (use_sib && sib[5:3] != 3'd4) ? r.gprs.val[sib[5:3]] << sib[7:6] : 32'd0;
    disp     = {r.instr[pos+3], r.instr[pos+2], r.instr[pos+1], r.instr[pos]};
    case (modrm[7:6])
      2'b00:   disp = (base_reg == 3'd5) ? disp : 32'd0;
      2'b01:   disp = {{24{disp[7]}}, disp[7:0]};
      2'b10:   disp = disp;
      default: disp = 32'd0;
    endcase
    return base + index + disp;
  endfunction

  function automatic opnd_pkg::decode_req_t make_request();
    opnd_pkg::decode_req_t r;
    logic [31:0]           word;
    r = '0;
    for (int b = 0; b < opnd_pkg::instr_bytes; b++) begin
      word       = random_bits(8);
      r.instr[b] = word[7:0];
    end
    // Steering rm and the SIB base toward 100 and 101 brings in SIB and no-base cases
    if (random_bits(1) != 0) begin
      r.instr[1][2:0] = 3'b100;
    end
    if (random_bits(1) != 0) begin
      r.instr[2][2:0] = 3'b101;
    end
    word        = random_bits(3);
    r.form      = opnd_pkg::opnd_form_e'(word[2:0] % 3'd6);
    word        = random_bits(2);
    r.cmd       = opnd_pkg::cmd_e'(word[1:0]);
    word        = random_bits(1);
    r.imm_1byte = word[0];
    for (int g = 0; g < opnd_pkg::reg_count; g++) begin
      r.gprs.val[g] = random_bits(32);
    end
    r.hint.data = random_bits(32);
    if (random_bits(1) != 0) begin
      r.hint.addr = target_address(r);
    end else begin
      r.hint.addr = random_bits(32);
    end
    return r;
  endfunction

  // Four-phase handshake, entered and left on a rising edge
  task automatic do_handshake(input opnd_pkg::decode_req_t r, input int hold);
    req     <= 1'b1;
    request <= r;
    do @(posedge clk); while (!ack);
    // Holding req models back-pressure, ack and result must stay put
    repeat (hold) @(posedge clk);
    req <= 1'b0;
    do @(posedge clk); while (ack);
  endtask

  initial begin
    opnd_pkg::decode_req_t r;
    logic [31:0]           word;
    lfsr    = 32'd19;
    req     = 1'b0;
    request = '0;
    arst_n  = 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    for (int n = 0; n < num_requests; n++) begin
      r    = make_request();
      word = random_bits(2);
      do_handshake(r, word[1:0]);
    end
    repeat (2) @(posedge clk);
    $display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Stops a run where the DUT never answers
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the requests did not complete within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

endmodule

/* tb/opnd_checker.sv */
`timescale 1ns/1ps

module opnd_checker (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     req,
  input  opnd_pkg::decode_req_t    request,
  input  logic                     ack,
  input  opnd_pkg::decode_result_t result,
  output int                       value_errors,
  output int                       protocol_errors
);

  opnd_pkg::decode_req_t    held;
  opnd_pkg::decode_result_t acked_result;
  logic                     pending;
  logic                     ack_prev;
  logic                     release_prev;
  logic                     reset_checked;
  int                       edges;
  int                       handshakes;

  // Up to four little-endian bytes at pos, sign-extended when only one is taken
  function automatic logic [31:0] bytes_at(
    input opnd_pkg::decode_req_t r,
    input int                    pos,
    input int                    n
  );
    logic [31:0] w;
    w = {r.instr[pos+3], r.instr[pos+2], r.instr[pos+1], r.instr[pos]};
    if (n == 1) begin
      w = {{24{w[7]}}, w[7:0]};
    end else if (n == 0) begin
      w = '0;
    end
    return w;
  endfunction

  function automatic opnd_pkg::decode_result_t expect_result(input opnd_pkg::decode_req_t r);
    opnd_pkg::decode_result_t e;
    logic [7:0]               modrm;
    logic [7:0]               sib;
    logic                     rm_form;
    logic                     imm_form;
    logic                     direct;
    logic                     use_sib;
    logic [2:0]               base_reg;
    logic [31:0]              imm;
    logic [31:0]              addr;
    logic [31:0]              mval;
    logic                     reg0;
    logic                     mem0;
    logic                     reg1;
    logic                     mem1;
    logic [2:0]               sel0;
    logic [2:0]               sel1;
    int                       pos;
    int                       disp_n;
    int                       imm_n;
    int                       len;
    e        = '0;
    modrm    = r.instr[1];
    sib      = r.instr[2];
    rm_form  = r.form == opnd_pkg::form_rm_reg || r.form == opnd_pkg::form_reg_rm ||
               r.form == opnd_pkg::form_rm_imm;
    imm_form = r.form == opnd_pkg::form_reg_imm || r.form == opnd_pkg::form_eax_imm ||
               r.form == opnd_pkg::form_rm_imm;
    direct   = modrm[7:6] == 2'b11;
    use_sib  = rm_form && !direct && modrm[2:0] == 3'd4;
    base_reg = use_sib ? sib[2:0] : modrm[2:0];
    // After the opcode come ModR/M, SIB, displacement and immediate in that order
    pos      = 1 + (rm_form ? 1 : 0) + (use_sib ? 1 : 0);
    disp_n   = 0;
    if (rm_form) begin
      case (modrm[7:6])
        2'b00:   disp_n = (base_reg == 3'd5) ? 4 : 0;
        2'b01:   disp_n = 1;
        2'b10:   disp_n = 4;
        default: disp_n = 0;
      endcase
    end
    imm_n      = imm_form ? (r.imm_1byte ? 1 : 4) : 0;
    imm        = bytes_at(r, pos + disp_n, imm_n);
    len        = (rm_form ? 1 : 0) + (use_sib ? 1 : 0) + disp_n + imm_n;
    e.body_len = len[3:0];
    // Base plus scaled index plus displacement, wrapping at 32 bits
    addr = bytes_at(r, pos, disp_n);
    if (!(modrm[7:6] == 2'b00 && base_reg == 3'd5)) begin
      addr = addr + r.gprs.val[base_reg];
    end
    if (use_sib && sib[5:3] != 3'd4) begin
      addr = addr + r.gprs.val[sib[5:3]] * (32'd1 << sib[7:6]);
    end
    if (r.cmd == opnd_pkg::cmd_lea) begin
      mval = addr;
    end else if (r.hint.addr == addr) begin
      mval = r.hint.data;
    end else begin
      mval = '0;
    end
    reg0 = 1'b0;
    mem0 = 1'b0;
    reg1 = 1'b0;
    mem1 = 1'b0;
    sel0 = modrm[2:0];
    sel1 = modrm[5:3];
    case (r.form)
      opnd_pkg::form_reg, opnd_pkg::form_reg_imm: begin
        reg0 = 1'b1;
        sel0 = r.instr[0][2:0];
      end
      opnd_pkg::form_eax_imm: begin
        reg0 = 1'b1;
        sel0 = opnd_pkg::reg_eax;
      end
      opnd_pkg::form_reg_rm: begin
        reg0 = 1'b1;
        sel0 = modrm[5:3];
        reg1 = direct;
        mem1 = !direct;
        sel1 = modrm[2:0];
      end
      opnd_pkg::form_rm_reg: begin
        reg0 = direct;
        mem0 = !direct;
        reg1 = 1'b1;
      end
      default: begin
        reg0 = direct;
        mem0 = !direct;
      end
    endcase
    e.opnd0 = reg0 ? r.gprs.val[sel0] : (mem0 ? mval : 32'd0);
    e.opnd1 = reg1 ? r.gprs.val[sel1] : (mem1 ? mval : imm);
    // CMP writes nothing back
    if (r.cmd == opnd_pkg::cmd_cmp) begin
      e.dest_kind = opnd_pkg::dest_none;
    end else if (reg0) begin
      e.dest_kind = opnd_pkg::dest_reg;
      e.dest_sel  = sel0;
    end else if (mem0) begin
      e.dest_kind = opnd_pkg::dest_mem;
    end
    return e;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h (request %0d)", name, got, exp, handshakes);
      value_errors++;
    end
  endtask

  task automatic check_result(input opnd_pkg::decode_req_t r);
    opnd_pkg::decode_result_t e;
    e = expect_result(r);
    compare("result.opnd0", result.opnd0, e.opnd0);
    compare("result.opnd1", result.opnd1, e.opnd1);
    compare("result.body_len", result.body_len, e.body_len);
    compare("result.dest_kind", result.dest_kind, e.dest_kind);
    compare("result.dest_sel", result.dest_sel, e.dest_sel);
  endtask

  // Samples on the rising edge, seeing the values that were settled before it
  always @(posedge clk) begin
    if (!arst_n) begin
      value_errors    = 0;
      protocol_errors = 0;
      pending         = 1'b0;
      ack_prev        = 1'b0;
      release_prev    = 1'b0;
      reset_checked   = 1'b0;
      edges           = 0;
      handshakes      = 0;
    end else begin
      if (!reset_checked) begin
        reset_checked = 1'b1;
        if (ack) begin
          $display("ack was high straight out of reset");
          protocol_errors++;
        end
        if (result !== '0) begin
          $display("Error: result after reset got %h expected %h", result, 32'h0);
          value_errors++;
        end
      end
      if (release_prev && ack) begin
        $display("ack stayed high after req was dropped (request %0d)", handshakes);
        protocol_errors++;
      end
      // Under back-pressure ack has to stay up until req is dropped
      if (ack_prev && !ack && req) begin
        $display("ack fell while req was still held (request %0d)", handshakes);
        protocol_errors++;
      end
      if (pending) begin
        edges++;
      end
      if (ack && !ack_prev) begin
        if (!pending) begin
          $display("ack rose while no request was pending");
          protocol_errors++;
        end else begin
          if (edges != 2) begin
            $display("ack rose %0d edges after req was sampled instead of 2", edges);
            protocol_errors++;
          end
          check_result(held);
          pending = 1'b0;
        end
        acked_result = result;
        handshakes++;
      end else if (ack && result !== acked_result) begin
        $display("Error: result changed while ack was high, got %h expected %h",
                 result, acked_result);
        value_errors++;
        acked_result = result;
      end
      // The DUT takes the request on the first edge that finds req high while idle
      if (req && !ack && !pending) begin
        held    = request;
        pending = 1'b1;
        edges   = 0;
      end
      release_prev = ack && !req;
      ack_prev     = ack;
    end
  end

endmodule

/* verilog/decode_opnds.sv */
`timescale 1ns/1ps

module decode_opnds (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     req,
  input  opnd_pkg::decode_req_t    request,
  output logic                     ack,
  output opnd_pkg::decode_result_t result
);

  logic                    load;
  opnd_pkg::decode_req_t   captured;
  opnd_pkg::instr_fields_t fields;
  opnd_pkg::reg_opnd_t     regs;
  opnd_pkg::mem_opnd_t     mem;

  // Handshake and the stable copy of the request
  request_ctrl u_request_ctrl (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .request  (request),
    .ack      (ack),
    .load     (load),
    .captured (captured)
  );

  instr_field_decode u_instr_field_decode (
    .captured (captured),
    .fields   (fields)
  );

  // The register and memory paths run side by side off the same fields
  reg_operand_select u_reg_operand_select (
    .captured (captured),
    .fields   (fields),
    .regs     (regs)
  );

  mem_address_gen u_mem_address_gen (
    .captured (captured),
    .fields   (fields),
    .mem      (mem)
  );

  operand_combine u_operand_combine (
    .clk      (clk),
    .arst_n   (arst_n),
    .load     (load),
    .fields   (fields),
    .captured (captured),
    .regs     (regs),
    .mem      (mem),
    .result   (result)
  );

endmodule

/* verilog/operand_combine.sv */
`timescale 1ns/1ps

module operand_combine (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     load,
  input  opnd_pkg::instr_fields_t  fields,
  input  opnd_pkg::decode_req_t    captured,
  input  opnd_pkg::reg_opnd_t      regs,
  input  opnd_pkg::mem_opnd_t      mem,
  output opnd_pkg::decode_result_t result
);

  logic                      opnd1_is_imm;
  opnd_pkg::dest_kind_e      dest_kind;
  opnd_pkg::decode_result_t  result_next;

  // In the kept forms the immediate only ever feeds operand 1
  assign opnd1_is_imm = captured.form inside {opnd_pkg::form_reg_imm, opnd_pkg::form_eax_imm,
                                              opnd_pkg::form_rm_imm};

  // CMP only sets flags, so nothing gets written back
  always_comb begin
    if (captured.cmd == opnd_pkg::cmd_cmp) begin
      dest_kind = opnd_pkg::dest_none;
    end else if (regs.opnd0_is_reg) begin
      dest_kind = opnd_pkg::dest_reg;
    end else if (mem.opnd0_is_mem) begin
      dest_kind = opnd_pkg::dest_mem;
    end else begin
      dest_kind = opnd_pkg::dest_none;
    end
  end

  // Register beats memory beats immediate
  always_comb begin
    result_next = '0;
    if (regs.opnd0_is_reg) begin
      result_next.opnd0 = regs.opnd0_val;
    end else if (mem.opnd0_is_mem) begin
      result_next.opnd0 = mem.value;
    end
    if (regs.opnd1_is_reg) begin
      result_next.opnd1 = regs.opnd1_val;
    end else if (mem.opnd1_is_mem) begin
      result_next.opnd1 = mem.value;
    end else if (opnd1_is_imm) begin
      result_next.opnd1 = fields.imm;
    end
    result_next.body_len  = fields.body_len;
    result_next.dest_kind = dest_kind;
    result_next.dest_sel  = (dest_kind == opnd_pkg::dest_reg) ? regs.opnd0_sel : '0;
  end

  // Held between loads so the output stays stable for the whole ack phase
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else if (load) begin
      result <= result_next;
    end
  end

endmodule

/* verilog/mem_address_gen.sv */
`timescale 1ns/1ps

module mem_address_gen (
  input  opnd_pkg::decode_req_t   captured,
  input  opnd_pkg::instr_fields_t fields,
  output opnd_pkg::mem_opnd_t     mem
);

  logic                              rm_is_mem;
  logic                              opnd0_is_mem;
  logic                              opnd1_is_mem;
  logic [opnd_pkg::regsel_width-1:0] base_sel;
  logic [opnd_pkg::regsel_width-1:0] index_sel;
  logic [1:0]                        scale;
  logic                              no_base;
  logic                              no_index;
  logic [opnd_pkg::word_width-1:0]   base_val;
  logic [opnd_pkg::word_width-1:0]   index_val;
  logic [opnd_pkg::word_width-1:0]   addr;
  logic                              hint_hit;
  logic [opnd_pkg::word_width-1:0]   value;

  // Any ModR/M with a mod other than 11 names memory through rm
  assign rm_is_mem = fields.has_modrm && !fields.rm_is_direct;

  // Which operand the rm side lands on depends on the form
  assign opnd0_is_mem = rm_is_mem &&
                        captured.form inside {opnd_pkg::form_rm_reg, opnd_pkg::form_rm_imm};
  assign opnd1_is_mem = rm_is_mem && captured.form == opnd_pkg::form_reg_rm;

  // With SIB the base comes from SIB.base, otherwise straight from ModR/M.rm
  assign base_sel  = fields.has_sib ? fields.sib[2:0] : fields.modrm[2:0];
  assign index_sel = fields.sib[5:3];
  assign scale     = fields.sib[7:6];

  // The EBP code under mod 00 means a disp32 takes the place of the base,
  // and this holds in both encodings
  assign no_base = fields.modrm[7:6] == 2'b00 && base_sel == opnd_pkg::reg_ebp;

  // ESP can never be an index, its code marks the index as absent
  assign no_index = !fields.has_sib || index_sel == opnd_pkg::reg_esp;

  assign base_val  = no_base ? '0 : captured.gprs.val[base_sel];
  assign index_val = no_index ? '0 : (captured.gprs.val[index_sel] << scale);

  // Sum wraps at 32 bits, as it does on the real machine
  assign addr = base_val + index_val + fields.disp;

  assign hint_hit = captured.hint.addr == addr;

  // LEA never touches memory and hands the address back as its value
  always_comb begin
    if (captured.cmd == opnd_pkg::cmd_lea) begin
      value = addr;
    end else if (hint_hit) begin
      value = captured.hint.data;
    end else begin
      value = '0;
    end
  end

  always_comb begin
    mem              = '0;
    mem.opnd0_is_mem = opnd0_is_mem;
    mem.opnd1_is_mem = opnd1_is_mem;
    mem.addr         = addr;
    mem.value        = value;
  end

endmodule

/* verilog/reg_operand_select.sv */
`timescale 1ns/1ps

module reg_operand_select (
  input  opnd_pkg::decode_req_t   captured,
  input  opnd_pkg::instr_fields_t fields,
  output opnd_pkg::reg_opnd_t     regs
);

  logic                              is_reg0;
  logic                              is_reg1;
  logic [opnd_pkg::regsel_width-1:0] sel0;
  logic [opnd_pkg::regsel_width-1:0] sel1;

  // Selectors stay at zero when an operand is not a register, which keeps
  // the destination selector clean further down
  always_comb begin
    is_reg0 = 1'b0;
    is_reg1 = 1'b0;
    sel0    = '0;
    sel1    = '0;
    case (captured.form)
      opnd_pkg::form_reg, opnd_pkg::form_reg_imm: begin
        // Register is packed into the low opcode bits
        is_reg0 = 1'b1;
        sel0    = captured.instr[0][2:0];
      end
      opnd_pkg::form_eax_imm: begin
        is_reg0 = 1'b1;
        sel0    = opnd_pkg::reg_eax;
      end
      opnd_pkg::form_rm_reg: begin
        is_reg0 = fields.rm_is_direct;
        sel0    = fields.rm_is_direct ? fields.modrm[2:0] : '0;
        is_reg1 = 1'b1;
        sel1    = fields.modrm[5:3];
      end
      opnd_pkg::form_reg_rm: begin
        is_reg0 = 1'b1;
        sel0    = fields.modrm[5:3];
        is_reg1 = fields.rm_is_direct;
        sel1    = fields.rm_is_direct ? fields.modrm[2:0] : '0;
      end
      opnd_pkg::form_rm_imm: begin
        is_reg0 = fields.rm_is_direct;
        sel0    = fields.rm_is_direct ? fields.modrm[2:0] : '0;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    regs              = '0;
    regs.opnd0_is_reg = is_reg0;
    regs.opnd0_sel    = sel0;
    regs.opnd0_val    = captured.gprs.val[sel0];
    regs.opnd1_is_reg = is_reg1;
    regs.opnd1_sel    = sel1;
    regs.opnd1_val    = captured.gprs.val[sel1];
  end

endmodule

/* verilog/instr_field_decode.sv */
`timescale 1ns/1ps

module instr_field_decode (
  input  opnd_pkg::decode_req_t   captured,
  output opnd_pkg::instr_fields_t fields
);

  logic [1:0]                       mod_bits;
  logic [2:0]                       rm_bits;
  logic                             has_modrm;
  logic                             has_sib;
  logic                             rm_is_direct;
  logic                             has_imm;
  logic                             disp_is_8;
  logic                             disp_is_32;
  logic [opnd_pkg::len_width-1:0]   disp_len;
  logic [opnd_pkg::len_width-1:0]   imm_len;
  logic [opnd_pkg::len_width-1:0]   disp_pos;
  logic [opnd_pkg::len_width-1:0]   imm_pos;
  logic [opnd_pkg::word_width-1:0]  disp_word;
  logic [opnd_pkg::word_width-1:0]  imm_word;

  // Gathers four little-endian bytes starting at pos
  function automatic logic [opnd_pkg::word_width-1:0] take_word(
    input logic [opnd_pkg::instr_bytes-1:0][7:0] bytes,
    input logic [opnd_pkg::len_width-1:0]        pos
  );
    logic [opnd_pkg::word_width-1:0] word;
    word = '0;
    for (int k = 0; k < 4; k++) begin
      word[8*k +: 8] = bytes[pos + k];
    end
    return word;
  endfunction

  // Keeps all 32 bits, or sign-extends the low byte
  function automatic logic [opnd_pkg::word_width-1:0] sext(
    input logic [opnd_pkg::word_width-1:0] word,
    input logic                            one_byte
  );
    return one_byte ? {{(opnd_pkg::word_width-8){word[7]}}, word[7:0]} : word;
  endfunction

  // Only the rm forms carry a ModR/M byte, always right after the opcode
  assign has_modrm = captured.form inside {opnd_pkg::form_rm_reg, opnd_pkg::form_reg_rm,
                                           opnd_pkg::form_rm_imm};
  assign has_imm   = captured.form inside {opnd_pkg::form_reg_imm, opnd_pkg::form_eax_imm,
                                           opnd_pkg::form_rm_imm};

  assign mod_bits     = captured.instr[1][7:6];
  assign rm_bits      = captured.instr[1][2:0];
  assign rm_is_direct = has_modrm && mod_bits == 2'b11;

  // An rm code of 100 with a memory mod escapes to a SIB byte
  assign has_sib = has_modrm && !rm_is_direct && rm_bits == opnd_pkg::reg_esp;

  // A code of 101 under mod 00 swaps the base register for a disp32,
  // both in ModR/M.rm and in SIB.base
  assign disp_is_32 = has_modrm &&
                      ((mod_bits == 2'b00 && !has_sib && rm_bits == opnd_pkg::reg_ebp) ||
                       (mod_bits == 2'b00 && has_sib &&
                        captured.instr[2][2:0] == opnd_pkg::reg_ebp) ||
                       mod_bits == 2'b10);
  assign disp_is_8  = has_modrm && mod_bits == 2'b01;

  assign disp_len = disp_is_32 ? 4'd4 : (disp_is_8 ? 4'd1 : 4'd0);
  assign imm_len  = has_imm ? (captured.imm_1byte ? 4'd1 : 4'd4) : 4'd0;

  // Each field starts where the previous one ends
  assign disp_pos = 4'd1 + {3'b000, has_modrm} + {3'b000, has_sib};
  assign imm_pos  = disp_pos + disp_len;

  assign disp_word = take_word(captured.instr, disp_pos);
  assign imm_word  = take_word(captured.instr, imm_pos);

  always_comb begin
    fields              = '0;
    fields.has_modrm    = has_modrm;
    fields.has_sib      = has_sib;
    fields.rm_is_direct = rm_is_direct;
    fields.modrm        = has_modrm ? captured.instr[1] : 8'h00;
    fields.sib          = has_sib ? captured.instr[2] : 8'h00;
    // Absent fields read as zero so the address adder needs no extra gating
    fields.disp         = (disp_len != 4'd0) ? sext(disp_word, disp_is_8) : '0;
    fields.imm          = has_imm ? sext(imm_word, captured.imm_1byte) : '0;
    fields.body_len     = {3'b000, has_modrm} + {3'b000, has_sib} + disp_len + imm_len;
  end

endmodule

/* verilog/request_ctrl.sv */
`timescale 1ns/1ps

module request_ctrl (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  req,
  input  opnd_pkg::decode_req_t request,
  output logic                  ack,
  output logic                  load,
  output opnd_pkg::decode_req_t captured
);

  opnd_pkg::ctrl_state_e state;
  opnd_pkg::ctrl_state_e state_next;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= opnd_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Idle waits for req, busy lasts exactly one cycle while the decode settles,
  // and done holds ack until the requester lets go of req
  always_comb begin
    state_next = state;
    case (state)
      opnd_pkg::st_idle: begin
        if (req) begin
          state_next = opnd_pkg::st_busy;
        end
      end
      opnd_pkg::st_busy: begin
        state_next = opnd_pkg::st_done;
      end
      opnd_pkg::st_done: begin
        if (!req) begin
          state_next = opnd_pkg::st_idle;
        end
      end
      default: begin
        state_next = opnd_pkg::st_idle;
      end
    endcase
  end

  // The request is taken only once per handshake, so the datapath never sees
  // the requester change its inputs mid-decode
  always_ff @(posedge clk) begin
    if (state == opnd_pkg::st_idle && req) begin
      captured <= request;
    end
  end

  // The result register loads on the edge that leaves st_busy
  assign load = (state == opnd_pkg::st_busy);
  assign ack  = (state == opnd_pkg::st_done);

endmodule

/* verilog/opnd_pkg.sv */
package opnd_pkg;

  // Operand and register width
  localparam int word_width = 32;

  // Opcode byte plus up to ten body bytes after the escape
  localparam int instr_bytes = 11;

  localparam int reg_count    = 8;
  localparam int regsel_width = 3;

  // Wide enough for the longest body, which is ten bytes
  localparam int len_width = 4;

  // General register numbers in the order the x86 encoding uses them
  localparam logic [regsel_width-1:0] reg_eax = 3'd0;
  localparam logic [regsel_width-1:0] reg_ecx = 3'd1;
  localparam logic [regsel_width-1:0] reg_edx = 3'd2;
  localparam logic [regsel_width-1:0] reg_ebx = 3'd3;
  localparam logic [regsel_width-1:0] reg_esp = 3'd4;
  localparam logic [regsel_width-1:0] reg_ebp = 3'd5;
  localparam logic [regsel_width-1:0] reg_esi = 3'd6;
  localparam logic [regsel_width-1:0] reg_edi = 3'd7;

  // Where the two operands come from
  typedef enum logic [2:0] {
    form_reg     = 3'd0,
    form_reg_imm = 3'd1,
    form_eax_imm = 3'd2,
    form_rm_reg  = 3'd3,
    form_reg_rm  = 3'd4,
    form_rm_imm  = 3'd5
  } opnd_form_e;

  typedef enum logic [1:0] {
    cmd_mov = 2'd0,
    cmd_add = 2'd1,
    cmd_cmp = 2'd2,
    cmd_lea = 2'd3
  } cmd_e;

  typedef enum logic [1:0] {
    dest_none = 2'd0,
    dest_reg  = 2'd1,
    dest_mem  = 2'd2
  } dest_kind_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_busy = 2'd1,
    st_done = 2'd2
  } ctrl_state_e;

  // Register snapshot, val[n] holds register number n
  typedef struct packed {
    logic [reg_count-1:0][word_width-1:0] val;
  } gpr_file_t;

  // A single read hint from memory
  typedef struct packed {
    logic [word_width-1:0] addr;
    logic [word_width-1:0] data;
  } mem_hint_t;

  // Byte 0 is the opcode and sits in the low bits
  typedef struct packed {
    logic [instr_bytes-1:0][7:0] instr;
    opnd_form_e                  form;
    cmd_e                        cmd;
    logic                        imm_1byte;
    gpr_file_t                   gprs;
    mem_hint_t                   hint;
  } decode_req_t;

  typedef struct packed {
    logic                  has_modrm;
    logic                  has_sib;
    logic                  rm_is_direct;
    logic [7:0]            modrm;
    logic [7:0]            sib;
    logic [word_width-1:0] disp;
    logic [word_width-1:0] imm;
    logic [len_width-1:0]  body_len;
  } instr_fields_t;

  typedef struct packed {
    logic                    opnd0_is_reg;
    logic [regsel_width-1:0] opnd0_sel;
    logic [word_width-1:0]   opnd0_val;
    logic                    opnd1_is_reg;
    logic [regsel_width-1:0] opnd1_sel;
    logic [word_width-1:0]   opnd1_val;
  } reg_opnd_t;

  // Only one operand can be memory, so one address and value serve both
  typedef struct packed {
    logic                  opnd0_is_mem;
    logic                  opnd1_is_mem;
    logic [word_width-1:0] addr;
    logic [word_width-1:0] value;
  } mem_opnd_t;

  typedef struct packed {
    logic [word_width-1:0]   opnd0;
    logic [word_width-1:0]   opnd1;
    logic [len_width-1:0]    body_len;
    dest_kind_e              dest_kind;
    logic [regsel_width-1:0] dest_sel;
  } decode_result_t;

endpackage
